//--- hw/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath width of the integer pipeline
`define EXEC_XLEN 32

// 32 architectural registers, r0 reads as zero
`define EXEC_REG_IDX_W 5

// carry, zero, sign, overflow
`define EXEC_FLAG_W 4

// bytes per instruction
`define EXEC_PC_STEP 4

`endif

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // instruction class as seen by execute
  typedef enum logic [4:0] {
    OP_ALU_REG    = 5'd0,
    OP_ALU_IMM    = 5'd1,
    OP_MEM_W_ABS  = 5'd3,
    OP_MEM_W_REL  = 5'd4,
    OP_MEM_W_RELI = 5'd5,
    OP_MEM_H_ABS  = 5'd6,
    OP_MEM_H_REL  = 5'd7,
    OP_MEM_H_RELI = 5'd8,
    OP_MEM_B_ABS  = 5'd9,
    OP_MEM_B_REL  = 5'd10,
    OP_MEM_B_RELI = 5'd11,
    OP_BRANCH     = 5'd12,
    OP_JAL_ABS    = 5'd13,
    OP_JAL_REL    = 5'd14
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SHL  = 5'd5,
    ALU_SHR  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_RSUB = 5'd16  // imm - src1 on the immediate form
  } alu_op_e;

  typedef enum logic [4:0] {
    BR_ALWAYS, BR_Z, BR_NZ, BR_S, BR_NS, BR_C, BR_NC, BR_O, BR_NO,
    BR_POS, BR_NPOS, BR_G, BR_GE, BR_L, BR_LE, BR_A, BR_AE, BR_B, BR_BE
  } branch_cond_e;

  localparam int unsigned FLAG_C = 0;
  localparam int unsigned FLAG_Z = 1;
  localparam int unsigned FLAG_S = 2;
  localparam int unsigned FLAG_O = 3;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

`include "exec_params.svh"

package pipe_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;

  typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;  // index 0 is the zero register

  typedef logic [`EXEC_FLAG_W-1:0] flags_t;

  // one enable per byte lane
  typedef logic [`EXEC_XLEN/8-1:0] byte_en_t;

  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } access_size_e;

endpackage

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/100ps
`default_nettype none

module operand_forward
  import pipe_pkg::*;
(
  input  wire reg_idx_t s_1,
  input  wire reg_idx_t s_2,
  input  wire reg_idx_t mem_tgt,
  input  wire reg_idx_t wb_tgt,
  input  wire reg_idx_t tgt_out,
  input  wire word_t    reg_out_1,
  input  wire word_t    reg_out_2,
  input  wire word_t    mem_result,
  input  wire word_t    wb_result,
  input  wire word_t    result,
  input  wire           bubble_in,
  input  wire           bubble_out,
  input  wire           is_load_out,
  input  wire           mem_is_load,
  input  wire           mem_bubble,
  output word_t         op1,
  output word_t         op2,
  output logic          stall
);

  logic own_live;
  logic own_load;
  logic mem_load;

  assign own_live = !bubble_out;
  assign own_load = is_load_out && !bubble_out;
  assign mem_load = mem_is_load && !mem_bubble;

  // youngest producer wins
  function automatic word_t pick(input reg_idx_t src, input word_t rf_val);
    word_t val;
    val = rf_val;
    if (src != '0) begin
      if (own_live && tgt_out == src) begin
        val = result;
      end else if (!mem_bubble && mem_tgt == src) begin
        val = mem_result;
      end else if (wb_tgt == src) begin
        val = wb_result;
      end
    end
    return val;
  endfunction

  // load data not ready until after mem
  function automatic logic load_hit(input reg_idx_t src);
    logic hit;
    hit = 1'b0;
    if (src != '0) begin
      hit = (own_load && tgt_out == src) || (mem_load && mem_tgt == src);
    end
    return hit;
  endfunction

  always_comb begin
    op1 = pick(s_1, reg_out_1);
    op2 = pick(s_2, reg_out_2);
  end

  always_comb begin
    stall = !bubble_in && (load_hit(s_1) || load_hit(s_2));
  end

endmodule

`default_nettype wire

//--- hw/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module exec_alu
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               halt,
  input  wire               bubble_in,
  input  wire               stall,
  input  wire               is_branch,
  input  wire opcode_e      opcode,
  input  wire alu_op_e      alu_op,
  input  wire branch_cond_e branch_code,
  input  wire word_t        imm,
  input  wire word_t        pc,
  input  wire word_t        op1,
  input  wire word_t        op2,
  output word_t             alu_result,
  output flags_t            flags,
  output logic              branch,
  output word_t             branch_tgt
);

  localparam int W    = `EXEC_XLEN;
  localparam int SH_W = $clog2(`EXEC_XLEN);

  logic          is_rsub;
  logic          is_sub;
  logic          use_imm;
  word_t         lhs;
  word_t         rhs;
  word_t         rhs_add;
  logic [W:0]    sum;
  logic          arith;
  flags_t        flags_next;
  logic          taken;

  assign is_rsub = (opcode == OP_ALU_IMM) && (alu_op == ALU_RSUB);
  assign use_imm = (opcode == OP_ALU_IMM) || (opcode inside {[OP_MEM_W_ABS:OP_MEM_B_RELI]});

  assign lhs = is_rsub ? imm : op1;
  assign rhs = is_rsub ? op1 : use_imm ? imm : op2;

  // one adder for add, sub and rsub
  assign is_sub  = (alu_op == ALU_SUB) || (alu_op == ALU_RSUB);
  assign arith   = is_sub || (alu_op == ALU_ADD);
  assign rhs_add = is_sub ? ~rhs : rhs;
  assign sum     = {1'b0, lhs} + {1'b0, rhs_add} + {{W{1'b0}}, is_sub};

  always_comb begin
    unique case (alu_op)
      ALU_ADD, ALU_SUB, ALU_RSUB: alu_result = sum[W-1:0];
      ALU_AND: alu_result = lhs & rhs;
      ALU_OR:  alu_result = lhs | rhs;
      ALU_XOR: alu_result = lhs ^ rhs;
      ALU_SHL: alu_result = lhs << rhs[SH_W-1:0];
      ALU_SHR: alu_result = lhs >> rhs[SH_W-1:0];
      ALU_SRA: alu_result = $signed(lhs) >>> rhs[SH_W-1:0];
      default: alu_result = '0;
    endcase
  end

  // carry is not-borrow on subtract; c and o only from the adder
  always_comb begin
    flags_next         = '0;
    flags_next[FLAG_Z] = (alu_result == '0);
    flags_next[FLAG_S] = alu_result[W-1];
    if (arith) begin
      flags_next[FLAG_C] = sum[W];
      flags_next[FLAG_O] = (lhs[W-1] == rhs_add[W-1]) && (sum[W-1] != lhs[W-1]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (halt) begin
      flags <= '0;
    end else if (!bubble_in && !stall &&
                 (opcode == OP_ALU_REG || opcode == OP_ALU_IMM)) begin
      flags <= flags_next;
    end
  end

  always_comb begin
    unique case (branch_code)
      BR_ALWAYS: taken = 1'b1;
      BR_Z:      taken = flags[FLAG_Z];
      BR_NZ:     taken = !flags[FLAG_Z];
      BR_S:      taken = flags[FLAG_S];
      BR_NS:     taken = !flags[FLAG_S];
      BR_C:      taken = flags[FLAG_C];
      BR_NC:     taken = !flags[FLAG_C];
      BR_O:      taken = flags[FLAG_O];
      BR_NO:     taken = !flags[FLAG_O];
      BR_POS:    taken = !flags[FLAG_Z] && !flags[FLAG_S];
      BR_NPOS:   taken = flags[FLAG_Z] || flags[FLAG_S];
      BR_G:      taken = (flags[FLAG_S] == flags[FLAG_O]) && !flags[FLAG_Z];
      BR_GE:     taken = flags[FLAG_S] == flags[FLAG_O];
      BR_L:      taken = flags[FLAG_S] != flags[FLAG_O];
      BR_LE:     taken = (flags[FLAG_S] != flags[FLAG_O]) || flags[FLAG_Z];
      BR_A:      taken = !flags[FLAG_Z] && flags[FLAG_C];  // unsigned compares
      BR_AE:     taken = flags[FLAG_C] || flags[FLAG_Z];
      BR_B:      taken = !flags[FLAG_C] && !flags[FLAG_Z];
      BR_BE:     taken = !flags[FLAG_C] || flags[FLAG_Z];
      default:   taken = 1'b0;
    endcase
  end

  assign branch = is_branch && !bubble_in && taken;

  always_comb begin
    unique case (opcode)
      OP_BRANCH:  branch_tgt = pc + (imm << 2) + word_t'(`EXEC_PC_STEP);
      OP_JAL_ABS: branch_tgt = op1;
      OP_JAL_REL: branch_tgt = pc + op1 + word_t'(`EXEC_PC_STEP);
      default:    branch_tgt = pc + word_t'(`EXEC_PC_STEP);  // fall through
    endcase
  end

endmodule

`default_nettype wire

//--- hw/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module result_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           halt,
  input  wire           bubble_in,
  input  wire           stall,
  input  wire           is_load,
  input  wire           is_store,
  input  wire opcode_e  opcode,
  input  wire reg_idx_t tgt,
  input  wire word_t    pc,
  input  wire word_t    op2,
  input  wire word_t    alu_result,
  input  wire flags_t   flags,
  output word_t         result,
  output word_t         addr,
  output word_t         store_data,
  output reg_idx_t      tgt_out,
  output opcode_e       opcode_out,
  output logic          bubble_out,
  output logic          is_load_out,
  output logic          mem_re,
  output byte_en_t      we,
  output flags_t        flags_out
);

  access_size_e size;
  logic         is_mem;
  logic         is_rel;
  logic         live;
  logic         we_bit;
  word_t        mem_addr;
  word_t        lane_data;
  byte_en_t     lane_we;

  always_comb begin
    size   = SIZE_WORD;
    is_mem = 1'b1;
    is_rel = 1'b1;
    unique case (opcode)
      OP_MEM_W_ABS: is_rel = 1'b0;
      OP_MEM_W_REL, OP_MEM_W_RELI: size = SIZE_WORD;
      OP_MEM_H_ABS: begin
        size   = SIZE_HALF;
        is_rel = 1'b0;
      end
      OP_MEM_H_REL, OP_MEM_H_RELI: size = SIZE_HALF;
      OP_MEM_B_ABS: begin
        size   = SIZE_BYTE;
        is_rel = 1'b0;
      end
      OP_MEM_B_REL, OP_MEM_B_RELI: size = SIZE_BYTE;
      default: begin
        is_mem = 1'b0;
        is_rel = 1'b0;
      end
    endcase
  end

  assign mem_addr = !is_mem ? '0 :
                    is_rel  ? alu_result + pc + word_t'(`EXEC_PC_STEP) :
                              alu_result;

  assign live   = !bubble_in && !stall;
  assign we_bit = is_store && is_mem && live;

  // move the store value into the addressed lanes
  always_comb begin
    unique case (size)
      SIZE_HALF: begin
        lane_data = word_t'(op2[15:0]) << {mem_addr[1], 4'b0000};
        lane_we   = byte_en_t'(4'b0011) << {mem_addr[1], 1'b0};
      end
      SIZE_BYTE: begin
        lane_data = word_t'(op2[7:0]) << {mem_addr[1:0], 3'b000};
        lane_we   = byte_en_t'(4'b0001) << mem_addr[1:0];
      end
      default: begin
        lane_data = op2;
        lane_we   = '1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bubble_out  <= 1'b1;
      tgt_out     <= '0;
      is_load_out <= 1'b0;
      mem_re      <= 1'b0;
      we          <= '0;
      flags_out   <= '0;
    end else if (halt) begin
      bubble_out  <= 1'b1;
      tgt_out     <= '0;
      is_load_out <= 1'b0;
      mem_re      <= 1'b0;
      we          <= '0;
      flags_out   <= '0;
    end else begin
      bubble_out  <= !live;
      tgt_out     <= live ? tgt : '0;  // stalled slot writes nothing
      is_load_out <= live && is_load;
      mem_re      <= live && is_load;
      we          <= we_bit ? lane_we : '0;
      flags_out   <= flags;
    end
  end

  always_ff @(posedge clk) begin
    result     <= (opcode == OP_JAL_ABS || opcode == OP_JAL_REL) ?
                  pc + word_t'(`EXEC_PC_STEP) : alu_result;  // link address
    addr       <= mem_addr;
    store_data <= lane_data;
    opcode_out <= opcode;
  end

endmodule

`default_nettype wire

//--- hw/exec_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exec_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               halt,
  // decode
  input  wire               bubble_in,
  input  wire opcode_e      opcode,
  input  wire alu_op_e      alu_op,
  input  wire branch_cond_e branch_code,
  input  wire word_t        imm,
  input  wire reg_idx_t     s_1,
  input  wire reg_idx_t     s_2,
  input  wire reg_idx_t     tgt,
  input  wire               is_load,
  input  wire               is_store,
  input  wire               is_branch,
  input  wire word_t        pc,
  input  wire word_t        reg_out_1,
  input  wire word_t        reg_out_2,
  // later stages
  input  wire reg_idx_t     mem_tgt,
  input  wire word_t        mem_result,
  input  wire               mem_is_load,
  input  wire               mem_bubble,
  input  wire reg_idx_t     wb_tgt,
  input  wire word_t        wb_result,
  // to memory stage
  output word_t             result,
  output reg_idx_t          tgt_out,
  output opcode_e           opcode_out,
  output logic              bubble_out,
  output logic              is_load_out,
  output word_t             addr,
  output logic              mem_re,
  output word_t             store_data,
  output byte_en_t          we,
  output flags_t            flags_out,
  // same cycle
  output logic              stall,
  output logic              branch,
  output word_t             branch_tgt
);

  word_t  op1;
  word_t  op2;
  word_t  alu_result;
  flags_t flags;

  operand_forward u_forward (
    .s_1         (s_1),
    .s_2         (s_2),
    .mem_tgt     (mem_tgt),
    .wb_tgt      (wb_tgt),
    .tgt_out     (tgt_out),
    .reg_out_1   (reg_out_1),
    .reg_out_2   (reg_out_2),
    .mem_result  (mem_result),
    .wb_result   (wb_result),
    .result      (result),
    .bubble_in   (bubble_in),
    .bubble_out  (bubble_out),
    .is_load_out (is_load_out),
    .mem_is_load (mem_is_load),
    .mem_bubble  (mem_bubble),
    .op1         (op1),
    .op2         (op2),
    .stall       (stall)
  );

  exec_alu u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .halt        (halt),
    .bubble_in   (bubble_in),
    .stall       (stall),
    .is_branch   (is_branch),
    .opcode      (opcode),
    .alu_op      (alu_op),
    .branch_code (branch_code),
    .imm         (imm),
    .pc          (pc),
    .op1         (op1),
    .op2         (op2),
    .alu_result  (alu_result),
    .flags       (flags),
    .branch      (branch),
    .branch_tgt  (branch_tgt)
  );

  result_stage u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .halt        (halt),
    .bubble_in   (bubble_in),
    .stall       (stall),
    .is_load     (is_load),
    .is_store    (is_store),
    .opcode      (opcode),
    .tgt         (tgt),
    .pc          (pc),
    .op2         (op2),
    .alu_result  (alu_result),
    .flags       (flags),
    .result      (result),
    .addr        (addr),
    .store_data  (store_data),
    .tgt_out     (tgt_out),
    .opcode_out  (opcode_out),
    .bubble_out  (bubble_out),
    .is_load_out (is_load_out),
    .mem_re      (mem_re),
    .we          (we),
    .flags_out   (flags_out)
  );

endmodule

`default_nettype wire

//--- tb/exec_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module exec_stage_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int MAX_CYCLES = 400;  // seven tests of under 50 cycles

  logic clk, rst_n, halt, bubble_in, is_load, is_store, is_branch;
  logic mem_is_load, mem_bubble;
  opcode_e opcode;
  alu_op_e alu_op;
  branch_cond_e branch_code;
  word_t imm, pc, reg_out_1, reg_out_2, mem_result, wb_result;
  reg_idx_t s_1, s_2, tgt, mem_tgt, wb_tgt;
  word_t result, addr, store_data, branch_tgt;
  reg_idx_t tgt_out;
  opcode_e opcode_out;
  logic bubble_out, is_load_out, mem_re, stall, branch;
  byte_en_t we;
  flags_t flags_out;

  // model of the registered outputs, compared one cycle after issue
  logic e_bub, e_ld, e_re, e_chk_res, e_chk_mem;
  reg_idx_t e_tgt;
  opcode_e e_op;
  word_t e_res, e_addr, e_sd;
  byte_en_t e_we;
  flags_t e_fo, ref_flags;
  logic [31:0] lcg_state = 32'h2ef7546f;
  int cycles = 0, errors = 0, checks = 0, tests = 0, test_err = 0;

  exec_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t alu_ref(input int op, input word_t x, input word_t y);
    case (op)
      0:       return x + y;
      1, 16:   return x - y;
      2:       return x & y;
      3:       return x | y;
      4:       return x ^ y;
      5:       return x << y[4:0];
      6:       return x >> y[4:0];
      7:       return word_t'($signed(x) >>> y[4:0]);
      default: return '0;
    endcase
  endfunction

  function automatic flags_t flags_ref(input int op, input word_t x, input word_t y);
    word_t r;
    logic [32:0] wide;
    flags_t f;
    r = alu_ref(op, x, y);
    f = '0;
    f[FLAG_Z] = (r == 0);
    f[FLAG_S] = r[31];
    if (op == 0) begin
      wide = {1'b0, x} + {1'b0, y};
      f[FLAG_C] = wide[32];
      f[FLAG_O] = (x[31] == y[31]) && (r[31] != x[31]);
    end else if (op == 1 || op == 16) begin
      f[FLAG_C] = (x >= y);  // no borrow
      f[FLAG_O] = (x[31] != y[31]) && (r[31] != x[31]);
    end
    return f;
  endfunction

  function automatic logic taken_ref(input int code, input flags_t f);
    logic c, z, s, o;
    {o, s, z, c} = f;
    case (code)
      0: return 1'b1;
      1: return z;
      2: return !z;
      3: return s;
      4: return !s;
      5: return c;
      6: return !c;
      7: return o;
      8: return !o;
      9: return !z && !s;
      10: return z || s;
      11: return (s == o) && !z;  // signed greater
      12: return s == o;
      13: return s != o;
      14: return (s != o) || z;
      15: return c && !z;  // unsigned above
      16: return c || z;
      17: return !c && !z;
      default: return !c || z;
    endcase
  endfunction

  function automatic word_t fwd_ref(input reg_idx_t src, input word_t rf);
    if (src == 0) return rf;
    if (!e_bub && e_tgt == src) return e_res;
    if (!mem_bubble && mem_tgt == src) return mem_result;
    if (wb_tgt == src) return wb_result;
    return rf;
  endfunction

  function automatic logic load_hit(input reg_idx_t src);
    return src != 0 && ((e_ld && !e_bub && e_tgt == src) ||
                        (mem_is_load && !mem_bubble && mem_tgt == src));
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // compare last edge's outputs, then this cycle's, then predict the next edge
  task automatic check_cycle();
    word_t a, b, x, y, ea;
    logic st, live, is_mem, is_jal;
    int sz;
    @(negedge clk);
    check("bubble_out", bubble_out, e_bub);
    check("tgt_out", tgt_out, e_tgt);
    check("is_load_out", is_load_out, e_ld);
    check("mem_re", mem_re, e_re);
    check("we", we, e_we);
    check("flags_out", flags_out, e_fo);
    if (e_chk_res) check("result", result, e_res);
    if (e_chk_res) check("opcode_out", opcode_out, e_op);
    if (e_chk_mem) check("addr", addr, e_addr);
    if (e_chk_mem) check("store_data", store_data, e_sd);
    a = fwd_ref(s_1, reg_out_1);
    b = fwd_ref(s_2, reg_out_2);
    st = !bubble_in && (load_hit(s_1) || load_hit(s_2));
    check("stall", stall, st);
    check("branch", branch, is_branch && !bubble_in && taken_ref(branch_code, ref_flags));
    case (opcode)
      OP_BRANCH:  check("branch_tgt", branch_tgt, pc + imm * 4 + `EXEC_PC_STEP);
      OP_JAL_ABS: check("branch_tgt", branch_tgt, a);
      OP_JAL_REL: check("branch_tgt", branch_tgt, pc + a + `EXEC_PC_STEP);
      default:    check("branch_tgt", branch_tgt, pc + `EXEC_PC_STEP);
    endcase
    x = (opcode == 1 && alu_op == 16) ? imm : a;
    y = (opcode == 1 && alu_op == 16) ? a :
        (opcode == 1 || (opcode >= 3 && opcode <= 11)) ? imm : b;
    live = !bubble_in && !st;
    is_mem = opcode >= 3 && opcode <= 11;
    is_jal = opcode == 13 || opcode == 14;
    sz = is_mem ? (opcode - 3) / 3 : 0;  // 0 word, 1 half, 2 byte
    ea = alu_ref(alu_op, x, y);
    if (is_mem && opcode != 3 && opcode != 6 && opcode != 9) ea = ea + pc + `EXEC_PC_STEP;
    e_chk_res = !halt;
    e_chk_mem = !halt && is_mem;
    e_op = opcode;
    e_res = is_jal ? pc + `EXEC_PC_STEP : alu_ref(alu_op, x, y);
    e_addr = ea;
    e_sd = (sz == 0) ? b : (sz == 1) ? (b[15:0] << (16 * ea[1])) : (b[7:0] << (8 * ea[1:0]));
    e_bub = halt || !live;
    e_tgt = (halt || !live) ? '0 : tgt;
    e_ld = !halt && live && is_load;
    e_re = e_ld;
    e_we = '0;
    if (!halt && live && is_store && is_mem)
      e_we = (sz == 0) ? 4'hf : (sz == 1) ? (4'b0011 << (2 * ea[1])) : (4'b0001 << ea[1:0]);
    e_fo = halt ? '0 : ref_flags;
    if (halt) ref_flags = '0;
    else if (live && (opcode == 0 || opcode == 1)) ref_flags = flags_ref(alu_op, x, y);
  endtask

  task automatic issue(input int opc, input int op, input reg_idx_t a_idx, input word_t a_val,
                       input reg_idx_t b_idx, input word_t b_val, input word_t im,
                       input reg_idx_t t);
    @(posedge clk);
    halt <= 1'b0;
    bubble_in <= 1'b0;
    opcode <= opcode_e'(opc);
    alu_op <= alu_op_e'(op);
    s_1 <= a_idx;
    reg_out_1 <= a_val;
    s_2 <= b_idx;
    reg_out_2 <= b_val;
    imm <= im;
    tgt <= t;
    is_load <= 1'b0;
    is_store <= 1'b0;
    is_branch <= 1'b0;
  endtask

  // empty slot with the later stages idle
  task automatic bubble();
    @(posedge clk);
    halt <= 1'b0;
    bubble_in <= 1'b1;
    is_branch <= 1'b0;
    mem_bubble <= 1'b1;
    mem_is_load <= 1'b0;
    mem_tgt <= '0;
    wb_tgt <= '0;
    check_cycle();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s %s, %0d errors", name, (errors == test_err) ? "ok" : "FAILED",
             errors - test_err);
    test_err = errors;
  endtask

  initial begin
    int op;
    int opc;
    word_t a;
    word_t b;
    e_bub = 1'b1;
    {e_ld, e_re, e_chk_res, e_chk_mem} = '0;
    {e_tgt, e_we, e_fo, ref_flags} = '0;
    rst_n = 1'b0;
    {halt, bubble_in, is_load, is_store, is_branch, mem_is_load} = '0;
    mem_bubble = 1'b1;
    opcode = OP_ALU_REG;
    alu_op = ALU_ADD;
    branch_code = BR_ALWAYS;
    {imm, pc, reg_out_1, reg_out_2, mem_result, wb_result} = '0;
    {s_1, s_2, tgt, mem_tgt, wb_tgt} = '0;
    bubble_in = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    check_cycle();  // reset values still on the outputs
    end_test("reset");

    for (int i = 0; i < 20; i++) begin
      opc = lcg() & 1;
      op = (lcg() % 9 == 8) ? 16 : lcg() % 8;
      if (op == 16 && opc == 0) op = 1;
      issue(opc, op, 1 + i % 3, lcg(), 4 + i % 5, lcg(), lcg(), 10 + i % 8);
      check_cycle();
    end
    bubble();
    end_test("alu");

    issue(0, 3, 1, 32'h1111_0001, 0, 0, 0, 5);  // r5 in own output
    check_cycle();
    issue(0, 3, 5, 32'h4444_0004, 0, 0, 0, 6);
    mem_bubble <= 1'b0;
    mem_tgt <= 5;
    mem_result <= 32'h2222_0002;
    wb_tgt <= 5;
    wb_result <= 32'h3333_0003;
    check_cycle();
    issue(0, 3, 5, 32'h4444_0004, 0, 0, 0, 0);  // own output now r6
    check_cycle();
    issue(0, 3, 5, 32'h4444_0004, 0, 0, 0, 0);
    mem_bubble <= 1'b1;
    check_cycle();
    issue(0, 3, 5, 32'h4444_0004, 0, 0, 0, 0);
    wb_tgt <= 9;
    check_cycle();
    issue(0, 0, 0, 32'h0000_0055, 0, 32'h0000_0066, 0, 0);  // r0 never forwarded
    check_cycle();
    bubble();
    end_test("forward");

    issue(3, 0, 1, 32'h100, 2, 0, 4, 7);
    is_load <= 1'b1;
    check_cycle();
    issue(0, 0, 7, lcg(), 2, lcg(), 0, 8);  // depends on the load
    check_cycle();
    issue(0, 0, 7, lcg(), 2, lcg(), 0, 8);
    check_cycle();
    issue(0, 0, 3, lcg(), 9, lcg(), 0, 8);
    mem_bubble <= 1'b0;
    mem_is_load <= 1'b1;
    mem_tgt <= 9;
    check_cycle();
    bubble();
    end_test("stall");

    for (int sz = 0; sz < 3; sz++) begin
      for (int lo = 0; lo < 4; lo++) begin
        issue(3 + 3 * sz + (lo % 2), 0, 1, 32'h0000_2000, 2, lcg(), lo, 0);
        pc <= lcg() & 32'hffff_fffc;
        is_store <= 1'b1;
        check_cycle();
      end
      issue(5 + 3 * sz, 0, 1, 32'h0000_3000, 2, lcg(), 2, 12);
      is_load <= 1'b1;
      check_cycle();
    end
    bubble();
    end_test("memory");

    for (int p = 0; p < 2; p++) begin
      a = (p == 0) ? 32'h8000_0000 : lcg();
      b = (p == 0) ? 32'h0000_0001 : a;
      issue(0, 1, 1, a, 2, b, 0, 0);  // sub sets the flags
      check_cycle();
      for (int c = 0; c < 19; c++) begin
        issue(12, 0, 3, lcg(), 0, 0, lcg() & 32'hff, 0);
        is_branch <= 1'b1;
        branch_code <= branch_cond_e'(c);
        pc <= lcg() & 32'hffff_fffc;
        check_cycle();
      end
    end
    for (int j = 13; j < 15; j++) begin
      issue(j, 0, 3, lcg() & 32'hffff_fffc, 0, 0, 0, 31);
      is_branch <= 1'b1;
      branch_code <= BR_ALWAYS;
      pc <= lcg() & 32'hffff_fffc;
      check_cycle();
    end
    bubble();
    end_test("branch");

    issue(1, 1, 1, 32'h0000_0010, 0, 0, 32'h0000_0010, 4);  // z and c set before the halt
    check_cycle();
    issue(3, 0, 1, lcg(), 2, lcg(), 0, 4);
    is_store <= 1'b1;
    halt <= 1'b1;
    check_cycle();
    bubble();
    bubble();
    issue(3, 0, 1, lcg(), 2, lcg(), 0, 4);
    is_load <= 1'b1;
    halt <= 1'b1;
    check_cycle();
    bubble();
    end_test("halt");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/operand_forward.sv
hw/exec_alu.sv
hw/result_stage.sv
hw/exec_stage.sv
tb/exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/operand_forward.sv
      - hw/exec_alu.sv
      - hw/result_stage.sv
      - hw/exec_stage.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/exec_stage_tb.sv
